//--- Bender.yml
package:
  name: host_mixer

sources:
  - hdl/mixer_pkg.sv
  - hdl/host_link.sv
  - hdl/cmd_decoder.sv
  - hdl/audio_mix.sv
  - hdl/host_top.sv
  - target: test
    files:
      - tests/host_link_props.sv
      - tests/tb_host_top.sv

//--- build.f
hdl/mixer_pkg.sv
hdl/host_link.sv
hdl/cmd_decoder.sv
hdl/audio_mix.sv
hdl/host_top.sv
tests/host_link_props.sv
tests/tb_host_top.sv

//--- hdl/audio_mix.sv
`timescale 1ns/1ps
`default_nettype none

module audio_mix
	import mixer_pkg::*;
(
	input  wire       clk_sys,
	input  wire       resetd,

	input  att_t      i_att,
	input  mix_mode_t i_mix,
	input  wire       i_core_signed,

	input  sample_t   i_core,
	input  sample_t   i_host,

	// Pre-mix sample of the opposite channel
	input  sample_t   i_pre,

	output sample_t   o_pre,
	output sample_t   o_out
);

	//////////////////////////////////////////////////////////////////////
	// Glitch filter
	//////////////////////////////////////////////////////////////////////

	sample_t d1;
	sample_t d2;
	sample_t d3;
	sample_t core_f;

	always_ff @(posedge clk_sys) begin
		d1 <= i_core;
		d2 <= d1;
		d3 <= d2;
	end

	// Only a value seen twice in a row gets through
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			core_f <= '0;
		end else if (d2 == d3) begin
			core_f <= d2;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sum, cross-feed, attenuation, clamp
	//////////////////////////////////////////////////////////////////////

	wide_sample_t a1;
	wide_sample_t a2;
	wide_sample_t a3;
	wide_sample_t a4;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			a4    <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Unsigned core audio is halved to keep the same headroom
			if (i_core_signed) begin
				a1 <= wide_sample_t'(core_f);
			end else begin
				a1 <= {2'b00, core_f[15:1]};
			end

			a2    <= a1 + i_host;
			o_pre <= a2[16:1];

			case (i_mix)
				MIX_NONE:  a3 <= a2;
				MIX_LIGHT: a3 <= a2 - (a2 >>> 3) + (i_pre >>> 2);
				MIX_HALF:  a3 <= a2 - (a2 >>> 2) + (i_pre >>> 1);
				MIX_FULL:  a3 <= (a2 >>> 1) + i_pre;
				default:   a3 <= a2;
			endcase

			if (i_att[4]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[3:0];
			end

			// Guard bit and sign disagree on overflow
			if (a4[16] != a4[15]) begin
				o_out <= a4[16] ? 16'sh8000 : 16'sh7fff;
			end else begin
				o_out <= a4[15:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
	import mixer_pkg::*;
(
	input  wire        clk_sys,
	input  wire        resetd,

	// Channel select from the host
	input  wire        i_io_sel,

	// Words from the link
	input  wire        i_word_stb,
	input  host_word_t i_word,

	// Status shown where the host does not take over
	input  led_byte_t  i_led_status,

	output att_t       o_att,
	output led_byte_t  o_led
);

	dec_state_t state;
	logic [7:0] cmd;

	led_byte_t  led_overtake;
	led_byte_t  led_state;

	//////////////////////////////////////////////////////////////////////
	// Command framing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state <= DEC_WAIT_CMD;
			cmd   <= 8'h00;
		end else if (~i_io_sel) begin
			// Deselect ends the current command
			state <= DEC_WAIT_CMD;
			cmd   <= 8'h00;
		end else if (i_word_stb && state == DEC_WAIT_CMD) begin
			state <= DEC_DATA;
			cmd   <= i_word[7:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Register writes
	//////////////////////////////////////////////////////////////////////

	// Every data word re-applies the held command
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			led_overtake <= '0;
			led_state    <= '0;
			o_att        <= '0;
		end else if (i_io_sel && i_word_stb && state == DEC_DATA) begin
			case (cmd)
				CMD_LED: begin
					led_overtake <= i_word[15:8];
					led_state    <= i_word[7:0];
				end
				CMD_VOLUME: begin
					o_att <= i_word[4:0];
				end
				default: begin
					// Unknown commands leave the registers alone
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Board LEDs
	//////////////////////////////////////////////////////////////////////

	// Overtake bit set picks the host state, clear picks status
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_led <= '0;
		end else begin
			o_led <= (led_overtake & led_state) | (~led_overtake & i_led_status);
		end
	end

endmodule

`default_nettype wire

//--- hdl/host_link.sv
`timescale 1ns/1ps
`default_nettype none

module host_link
	import mixer_pkg::*;
#(
	parameter int SYNC_STAGES = 2
)
(
	input  wire        clk_sys,
	input  wire        resetd,

	// Host side, four-phase req/ack
	input  wire        i_io_req,
	input  host_word_t i_io_din,
	output logic       o_io_ack,

	// One strobe per transfer
	output logic       o_word_stb,
	output host_word_t o_word
);

	// Request synchronizer, oldest stage on top
	logic [SYNC_STAGES-1:0] req_sync;
	logic                   req_s;

	assign req_s = req_sync[SYNC_STAGES-1];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			req_sync <= '0;
		end else begin
			req_sync <= {req_sync[SYNC_STAGES-2:0], i_io_req};
		end
	end

	// Ack follows the synchronized request
	// A new word is only taken while ack is still low
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_io_ack   <= 1'b0;
			o_word_stb <= 1'b0;
		end else begin
			o_word_stb <= req_s & ~o_io_ack;
			if (req_s & ~o_io_ack) begin
				o_io_ack <= 1'b1;
			end else if (~req_s) begin
				o_io_ack <= 1'b0;
			end
		end
	end

	// Host holds the word stable while req is high
	always_ff @(posedge clk_sys) begin
		if (req_s & ~o_io_ack) begin
			o_word <= i_io_din;
		end
	end

endmodule

`default_nettype wire

//--- hdl/host_top.sv
`timescale 1ns/1ps
`default_nettype none

module host_top
	import mixer_pkg::*;
#(
	parameter int SYNC_STAGES = 2
)
(
	input  wire        clk_sys,
	input  wire        resetd,

	// Host link
	input  wire        i_io_req,
	input  wire        i_io_sel,
	input  host_word_t i_io_din,
	output logic       o_io_ack,

	// Board LEDs
	input  led_byte_t  i_led_status,
	output led_byte_t  o_led,

	// Audio
	input  sample_t    i_core_l,
	input  sample_t    i_core_r,
	input  wire        i_core_signed,
	input  mix_mode_t  i_mix,
	input  sample_t    i_host_l,
	input  sample_t    i_host_r,
	output sample_t    o_audio_l,
	output sample_t    o_audio_r
);

	logic       word_stb;
	host_word_t word;
	att_t       att;

	sample_t    pre_l;
	sample_t    pre_r;

	//////////////////////////////////////////////////////////////////////
	// Host command path
	//////////////////////////////////////////////////////////////////////

	host_link #(
		.SYNC_STAGES (SYNC_STAGES)
	) link0 (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io_req   (i_io_req),
		.i_io_din   (i_io_din),
		.o_io_ack   (o_io_ack),
		.o_word_stb (word_stb),
		.o_word     (word)
	);

	cmd_decoder dec0 (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_sel     (i_io_sel),
		.i_word_stb   (word_stb),
		.i_word       (word),
		.i_led_status (i_led_status),
		.o_att        (att),
		.o_led        (o_led)
	);

	//////////////////////////////////////////////////////////////////////
	// Audio path, pre samples cross over
	//////////////////////////////////////////////////////////////////////

	audio_mix mix_l (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_att         (att),
		.i_mix         (i_mix),
		.i_core_signed (i_core_signed),
		.i_core        (i_core_l),
		.i_host        (i_host_l),
		.i_pre         (pre_r),
		.o_pre         (pre_l),
		.o_out         (o_audio_l)
	);

	audio_mix mix_r (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_att         (att),
		.i_mix         (i_mix),
		.i_core_signed (i_core_signed),
		.i_core        (i_core_r),
		.i_host        (i_host_r),
		.i_pre         (pre_l),
		.o_pre         (pre_r),
		.o_out         (o_audio_r)
	);

endmodule

`default_nettype wire

//--- hdl/mixer_pkg.sv
`default_nettype none

package mixer_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data widths
	//////////////////////////////////////////////////////////////////////

	// One word from the host link
	typedef logic [15:0] host_word_t;

	// Audio sample, two's complement
	typedef logic signed [15:0] sample_t;

	// Sample plus one guard bit for sums
	typedef logic signed [16:0] wide_sample_t;

	// Bit 4 mutes, bits 3..0 are the right shift
	typedef logic [4:0] att_t;

	// One bit per board LED
	typedef logic [7:0] led_byte_t;

	//////////////////////////////////////////////////////////////////////
	// State and mode encodings
	//////////////////////////////////////////////////////////////////////

	// Left/right cross-feed strength
	typedef enum logic [1:0] {
		MIX_NONE  = 2'd0,
		MIX_LIGHT = 2'd1,
		MIX_HALF  = 2'd2,
		MIX_FULL  = 2'd3
	} mix_mode_t;

	// First word after select is the command
	typedef enum logic {
		DEC_WAIT_CMD = 1'b0,
		DEC_DATA     = 1'b1
	} dec_state_t;

	// User-I/O command bytes
	localparam logic [7:0] CMD_LED    = 8'h25;
	localparam logic [7:0] CMD_VOLUME = 8'h26;

endpackage

`default_nettype wire

//--- tests/host_link_props.sv
`timescale 1ns/1ps
`default_nettype none

module host_link_props (
	input wire clk_sys,
	input wire resetd,
	input wire i_req_s,
	input wire i_io_ack,
	input wire i_word_stb
);

	// Assertion failures so far
	int unsigned fail_count = 0;

	// Ack only rises on a synchronized request
	ack_after_req: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(i_io_ack) |-> $past(i_req_s))
		else begin
			$error("o_io_ack rose while the synchronized request was low");
			fail_count++;
		end

	// Ack is held for as long as the request is
	ack_held: assert property (@(posedge clk_sys) disable iff (resetd)
		(i_io_ack && i_req_s) |=> i_io_ack)
		else begin
			$error("o_io_ack dropped before the request fell");
			fail_count++;
		end

	// One strobe per rising ack, none elsewhere
	stb_on_rise: assert property (@(posedge clk_sys) disable iff (resetd)
		i_word_stb == $rose(i_io_ack))
		else begin
			$error("o_word_stb does not match a rise of o_io_ack");
			fail_count++;
		end

endmodule

bind host_link host_link_props props0 (
	.clk_sys    (clk_sys),
	.resetd     (resetd),
	.i_req_s    (req_s),
	.i_io_ack   (o_io_ack),
	.i_word_stb (o_word_stb)
);

`default_nettype wire

//--- tests/tb_host_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_host_top
	import mixer_pkg::*;
();

	localparam int SYNC_STAGES = 2;
	localparam int CLK_PERIOD  = 8;
	localparam int N_HANDSHAKE = 200;
	localparam int N_LED       = 40;
	localparam int N_VOL_CMD   = 6;
	localparam int N_VOL_WORDS = 4;
	localparam int N_PER_MODE  = 8;
	localparam int N_CLAMP     = 16;

	// Cycle budget of about 20 per transfer and 30 per audio vector
	localparam int N_XFER   = N_HANDSHAKE + N_LED + N_VOL_CMD * (N_VOL_WORDS + 1) + 12;
	localparam int N_AUDIO  = N_VOL_CMD * N_VOL_WORDS + 8 * N_PER_MODE + N_CLAMP + 4;
	localparam int LIMIT_NS = (N_XFER * 20 + N_AUDIO * 30 + 200) * CLK_PERIOD;

	logic       clk_sys = 1'b0;
	logic       resetd;
	logic       i_io_req;
	logic       i_io_sel;
	host_word_t i_io_din;
	logic       o_io_ack;
	led_byte_t  i_led_status;
	led_byte_t  o_led;
	sample_t    i_core_l;
	sample_t    i_core_r;
	sample_t    i_host_l;
	sample_t    i_host_r;
	logic       i_core_signed;
	mix_mode_t  i_mix;
	sample_t    o_audio_l;
	sample_t    o_audio_r;
	integer     seed = 93564;

	// Reference model of the decoder registers
	led_byte_t  m_overtake;
	led_byte_t  m_state;
	att_t       m_att;
	logic [7:0] m_cmd;
	logic       m_in_data;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	host_top #(.SYNC_STAGES(SYNC_STAGES)) dut0 (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_io_req(i_io_req), .i_io_sel(i_io_sel), .i_io_din(i_io_din), .o_io_ack(o_io_ack),
		.i_led_status(i_led_status), .o_led(o_led),
		.i_core_l(i_core_l), .i_core_r(i_core_r), .i_core_signed(i_core_signed),
		.i_mix(i_mix), .i_host_l(i_host_l), .i_host_r(i_host_r),
		.o_audio_l(o_audio_l), .o_audio_r(o_audio_r)
	);

	//////////////////////////////////////////////////////////////////////
	// Model and checks
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Per LED, a set overtake bit shows the host state bit
	function automatic led_byte_t led_merge(led_byte_t overtake, led_byte_t state,
			led_byte_t status);
		led_byte_t leds;
		int b;
		for (b = 0; b < 8; b++) begin
			leds[b] = overtake[b] ? state[b] : status[b];
		end
		return leds;
	endfunction

	// Core converted to 17 bits, plus host
	function automatic int wide_sum(sample_t core, sample_t host, logic is_signed);
		int c;
		c = is_signed ? int'(core) : int'(core[15:1]);
		return c + int'(host);
	endfunction

	function automatic sample_t mix_model(int s, int s_other, mix_mode_t mode, att_t att);
		int p;
		int v;
		p = s_other >>> 1;
		case (mode)
			MIX_NONE:  v = s;
			MIX_LIGHT: v = s - (s >>> 3) + (p >>> 2);
			MIX_HALF:  v = s - (s >>> 2) + (p >>> 1);
			default:   v = (s >>> 1) + p;
		endcase
		v = att[4] ? 0 : (v >>> att[3:0]);
		if (v > 32767) begin
			v = 32767;
		end else if (v < -32768) begin
			v = -32768;
		end
		return sample_t'(v);
	endfunction

	function automatic sample_t big_sample(logic neg, logic [12:0] r);
		return neg ? {3'b100, r} : {3'b011, r};
	endfunction

	task automatic model_word(input host_word_t w);
		if (!m_in_data) begin
			m_cmd     = w[7:0];
			m_in_data = 1'b1;
		end else if (m_cmd == CMD_LED) begin
			m_overtake = w[15:8];
			m_state    = w[7:0];
		end else if (m_cmd == CMD_VOLUME) begin
			m_att = w[4:0];
		end
	endtask

	// Four-phase transfer, latency checked both ways
	task automatic send_word(input host_word_t w);
		int cycles;
		@(negedge clk_sys);
		i_io_din = w;
		@(negedge clk_sys);
		i_io_req = 1'b1;
		cycles   = 0;
		while (o_io_ack !== 1'b1) begin
			@(negedge clk_sys);
			cycles++;
		end
		check_value("o_io_ack rise latency", cycles, SYNC_STAGES + 1);
		i_io_req = 1'b0;
		cycles   = 0;
		while (o_io_ack !== 1'b0) begin
			@(negedge clk_sys);
			cycles++;
		end
		check_value("o_io_ack fall latency", cycles, SYNC_STAGES + 1);
		model_word(w);
	endtask

	task automatic reselect();
		@(negedge clk_sys);
		i_io_sel = 1'b0;
		repeat (2) @(negedge clk_sys);
		i_io_sel  = 1'b1;
		m_in_data = 1'b0;
	endtask

	task automatic check_leds();
		@(negedge clk_sys);
		i_led_status = led_byte_t'($random(seed));
		repeat (2) @(negedge clk_sys);
		check_value("o_led", o_led, led_merge(m_overtake, m_state, i_led_status));
	endtask

	task automatic check_audio(input sample_t cl, input sample_t cr, input sample_t hl,
			input sample_t hr, input logic sgn, input mix_mode_t mode);
		int sl;
		int sr;
		@(negedge clk_sys);
		i_core_l      = cl;
		i_core_r      = cr;
		i_host_l      = hl;
		i_host_r      = hr;
		i_core_signed = sgn;
		i_mix         = mode;
		repeat (20) @(negedge clk_sys);
		sl = wide_sum(cl, hl, sgn);
		sr = wide_sum(cr, hr, sgn);
		check_value("o_audio_l", o_audio_l, mix_model(sl, sr, mode, m_att));
		check_value("o_audio_r", o_audio_r, mix_model(sr, sl, mode, m_att));
	endtask

	task automatic random_audio();
		check_audio(sample_t'($random(seed)), sample_t'($random(seed)),
			sample_t'($random(seed)), sample_t'($random(seed)),
			1'($random(seed)), mix_mode_t'(2'($random(seed))));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		#(LIMIT_NS);
		$display("Timeout: the tests did not finish within %0d ns", LIMIT_NS);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	// Stop at the first handshake assertion failure
	always @(negedge clk_sys) begin
		if (dut0.link0.props0.fail_count != 0) begin
			$display("A handshake assertion on the host link failed");
			$display("sim failed");
			$fatal(1, "assertion failure");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int i;
		int j;
		host_word_t w;
		sample_t lim;
		resetd        = 1'b1;
		i_io_req      = 1'b0;
		i_io_sel      = 1'b0;
		i_io_din      = '0;
		i_led_status  = '0;
		i_core_l      = '0;
		i_core_r      = '0;
		i_host_l      = '0;
		i_host_r      = '0;
		i_core_signed = 1'b0;
		i_mix         = MIX_NONE;
		m_overtake    = '0;
		m_state       = '0;
		m_att         = '0;
		m_cmd         = '0;
		m_in_data     = 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		resetd = 1'b0;
		check_value("o_io_ack", o_io_ack, 0);
		check_value("o_led", o_led, 0);
		check_value("o_audio_l", o_audio_l, 0);
		check_value("o_audio_r", o_audio_r, 0);

		// Random words, with a reselect now and then
		i_io_sel = 1'b1;
		for (i = 0; i < N_HANDSHAKE; i++) begin
			if (($random(seed) & 15) == 0) begin
				reselect();
			end
			send_word(host_word_t'($random(seed)));
			check_leds();
		end

		reselect();
		send_word({8'h00, CMD_LED});
		for (i = 0; i < N_LED; i++) begin
			send_word(host_word_t'($random(seed)));
			check_leds();
		end

		// Last volume word of each command mutes
		for (i = 0; i < N_VOL_CMD; i++) begin
			reselect();
			send_word({8'h00, CMD_VOLUME});
			for (j = 0; j < N_VOL_WORDS; j++) begin
				w    = host_word_t'($random(seed));
				w[4] = (j == N_VOL_WORDS - 1);
				send_word(w);
				random_audio();
			end
		end

		// Unknown command, then a fresh frame starting with CMD_LED
		reselect();
		send_word(16'h257f);
		for (i = 0; i < 4; i++) begin
			send_word(host_word_t'($random(seed)));
			check_leds();
		end
		random_audio();
		reselect();
		send_word({8'hff, CMD_LED});
		check_leds();
		send_word(16'h0fa5);
		check_leds();

		reselect();
		send_word({8'h00, CMD_VOLUME});
		send_word(16'h0000);
		for (i = 0; i < 8 * N_PER_MODE; i++) begin
			check_audio(sample_t'($random(seed)), sample_t'($random(seed)),
				sample_t'($random(seed)), sample_t'($random(seed)),
				i[3], mix_mode_t'(i[5:4]));
		end

		for (i = 0; i < N_CLAMP; i++) begin
			lim = i[0] ? 16'sh8000 : 16'sh7fff;
			check_audio(big_sample(i[0], 13'($random(seed))),
				big_sample(i[0], 13'($random(seed))),
				big_sample(i[0], 13'($random(seed))),
				big_sample(i[0], 13'($random(seed))),
				1'b1, mix_mode_t'(i[2:1]));
			check_value("o_audio_l", o_audio_l, lim);
			check_value("o_audio_r", o_audio_r, lim);
		end

		if (dut0.link0.props0.fail_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("Handshake assertions failed %0d times", dut0.link0.props0.fail_count);
			$display("sim failed");
			$fatal(1, "assertion failures");
		end
	end

endmodule

`default_nettype wire
